// File: pingpong_tile_buffer.f
+incdir+hw
hw/tile_buffer_pkg.sv
hw/pixel_write_addr.sv
hw/tile_bank.sv
hw/pingpong_ctrl.sv
hw/row_reader.sv
hw/pingpong_tile_buffer.sv
test/tb_clock_gen.sv
test/tb_pingpong_tile_buffer.sv

// File: Makefile
SIM  := obj_dir/Vtb_pingpong_tile_buffer
SRCS := pingpong_tile_buffer.f $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_pingpong_tile_buffer -f pingpong_tile_buffer.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_pingpong_tile_buffer.sv
`include "tile_buffer_macros.svh"

module tb_pingpong_tile_buffer
    import tile_buffer_pkg::*;
();

    localparam int TILE_PIX   = `TILE_DIM * `TILE_DIM;
    localparam int ROW_W      = `TILE_DIM * `PIXEL_W;
    localparam int MAX_CYCLES = 12000;

    logic      clk;
    logic      reset;
    logic      in_frame_start;
    logic      in_pixel_valid;
    pixel_t    in_pixel;
    logic      in_ready;
    logic      out_row_req;
    logic      tile_ready;
    logic      out_row_valid;
    tile_row_t out_row;
    logic      overflow;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     test_mark;
    int     cycles;
    string  test_name;

    // Model state.
    pixel_t           part_pix[$]; // Tile being filled.
    pixel_t           done_pix[$]; // Complete tiles, oldest first.
    int               m_full;
    int               m_rd_row;
    logic             m_overflow;
    logic             exp_valid;
    logic [ROW_W-1:0] exp_row;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    pingpong_tile_buffer u_dut (
        .clk            (clk),
        .reset          (reset),
        .in_frame_start (in_frame_start),
        .in_pixel_valid (in_pixel_valid),
        .in_pixel       (in_pixel),
        .in_ready       (in_ready),
        .out_row_req    (out_row_req),
        .tile_ready     (tile_ready),
        .out_row_valid  (out_row_valid),
        .out_row        (out_row),
        .overflow       (overflow)
    );

    // Column 0 goes to bits 271:264.
    function automatic logic [ROW_W-1:0] ref_row(input int row);
        logic [ROW_W-1:0] r;
        r = '0;
        for (int c = 0; c < `TILE_DIM; c++) begin
            r[ROW_W-1-c*`PIXEL_W -: `PIXEL_W] = done_pix[row*`TILE_DIM + c];
        end
        return r;
    endfunction

    task automatic model_step();
        logic can_wr;
        logic acc_rd;
        int   delta;
        can_wr = (m_full < 2);
        acc_rd = out_row_req && (m_full > 0);
        delta  = 0;
        if (in_pixel_valid && !can_wr) begin
            m_overflow = 1'b1;
        end
        exp_valid = acc_rd;
        if (acc_rd) begin
            exp_row = ref_row(m_rd_row);
            if (m_rd_row == `TILE_DIM - 1) begin
                repeat (TILE_PIX) void'(done_pix.pop_front()); // Oldest tile drained.
                m_rd_row = 0;
                delta    = -1;
            end else begin
                m_rd_row++;
            end
        end
        if (in_frame_start) begin
            part_pix.delete();
        end else if (in_pixel_valid && can_wr) begin
            part_pix.push_back(in_pixel);
            if (part_pix.size() == TILE_PIX) begin
                foreach (part_pix[i]) done_pix.push_back(part_pix[i]);
                part_pix.delete();
                delta++;
            end
        end
        m_full += delta;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            part_pix.delete();
            done_pix.delete();
            m_full     = 0;
            m_rd_row   = 0;
            m_overflow = 1'b0;
            exp_valid  = 1'b0;
        end else begin
            model_step();
        end
    end

    task automatic check(input string what, input logic [ROW_W-1:0] expected,
                         input logic [ROW_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // Outputs only change on the rising edge.
    always @(negedge clk) begin
        if (!reset) begin
            check("out_row_valid", exp_valid, out_row_valid);
            if (exp_valid && out_row_valid) begin
                check("out_row", exp_row, out_row);
            end
            check("in_ready", m_full < 2, in_ready);
            check("tile_ready", m_full > 0, tile_ready);
            check("overflow", m_overflow, overflow);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic write_pixels(input int n, input logic with_reads);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            in_pixel       = pixel_t'($random(seed));
            in_pixel_valid = in_ready; // Holds off while both banks are full.
            out_row_req    = with_reads && (($random(seed) & 15) == 0);
            if (in_ready) begin
                sent++;
            end
        end
        @(negedge clk);
        in_pixel_valid = 1'b0;
        out_row_req    = 1'b0;
    endtask

    task automatic offer_blocked(input int n);
        repeat (n) begin
            @(negedge clk);
            in_pixel_valid = 1'b1;
            in_pixel       = pixel_t'($random(seed));
        end
        @(negedge clk);
        in_pixel_valid = 1'b0;
    endtask

    task automatic read_rows(input int n);
        int issued;
        issued = 0;
        while (issued < n) begin
            @(negedge clk);
            out_row_req = tile_ready;
            if (tile_ready) begin
                issued++;
            end
        end
        @(negedge clk);
        out_row_req = 1'b0;
    endtask

    task automatic drain_tiles();
        @(negedge clk);
        while (tile_ready) begin
            out_row_req = 1'b1;
            @(negedge clk);
        end
        out_row_req = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_mark = errors;
    endtask

    task automatic end_test();
        repeat (2) @(negedge clk); // Let the last row reach the compare.
        tests++;
        if (errors == test_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_mark);
        end
    endtask

    initial begin
        seed           = 36;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        cycles         = 0;
        test_name      = "reset";
        in_frame_start = 1'b0;
        in_pixel_valid = 1'b0;
        in_pixel       = '0;
        out_row_req    = 1'b0;
        wait (reset == 1'b0);
        @(negedge clk);

        start_test("reset_and_one_tile");
        check("in_ready after reset", 1, in_ready);
        check("tile_ready after reset", 0, tile_ready);
        check("overflow after reset", 0, overflow);
        write_pixels(TILE_PIX, 1'b0);
        read_rows(`TILE_DIM);
        end_test();

        start_test("two_tiles_back_to_back");
        write_pixels(2 * TILE_PIX, 1'b0);
        check("in_ready with both banks full", 0, in_ready);
        read_rows(`TILE_DIM);
        check("in_ready after first drain", 1, in_ready);
        end_test();

        // Second tile of the previous test is still unread.
        start_test("overflow_drop");
        write_pixels(TILE_PIX, 1'b0);
        check("in_ready before drop", 0, in_ready);
        offer_blocked(40);
        check("overflow after drop", 1, overflow);
        read_rows(2 * `TILE_DIM);
        end_test();

        start_test("frame_start_restart");
        write_pixels(500, 1'b0);
        @(negedge clk);
        in_frame_start = 1'b1;
        @(negedge clk);
        in_frame_start = 1'b0;
        write_pixels(TILE_PIX, 1'b0);
        read_rows(`TILE_DIM);
        end_test();

        start_test("request_without_tile");
        repeat (5) begin
            @(negedge clk);
            check("valid without tile", 0, out_row_valid);
            out_row_req = 1'b1;
        end
        @(negedge clk);
        out_row_req = 1'b0;
        write_pixels(TILE_PIX, 1'b0);
        @(negedge clk);
        out_row_req = 1'b1;
        @(negedge clk);
        out_row_req = 1'b0;
        check("valid one cycle after request", 1, out_row_valid);
        @(negedge clk);
        check("single valid per request", 0, out_row_valid);
        end_test();

        // Rows 1 to 33 of the last tile are read while the next one fills.
        start_test("interleaved_read_write");
        write_pixels(TILE_PIX, 1'b1);
        drain_tiles();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // Period of 10, first rising edge at 5.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Covers the rising edges at 5 and 15, released on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: hw/pingpong_tile_buffer.sv
`include "tile_buffer_macros.svh"

module pingpong_tile_buffer
    import tile_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_frame_start,
    input  logic      in_pixel_valid,
    input  pixel_t    in_pixel,
    output logic      in_ready,
    input  logic      out_row_req,
    output logic      tile_ready,
    output logic      out_row_valid,
    output tile_row_t out_row,
    output logic      overflow
);

    logic [1:0] bank_wr_en;
    logic       rd_bank;
    tile_idx_t  wr_row;
    tile_idx_t  wr_col;
    logic       tile_written;
    tile_idx_t  rd_row;
    logic       tile_read_done;
    tile_row_t  bank_row0;
    tile_row_t  bank_row1;

    pixel_write_addr u_write_addr (
        .clk            (clk),
        .reset          (reset),
        .in_frame_start (in_frame_start),
        .wr_any         (|bank_wr_en),
        .wr_row         (wr_row),
        .wr_col         (wr_col),
        .tile_written   (tile_written)
    );

    pingpong_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .in_pixel_valid (in_pixel_valid),
        .tile_written   (tile_written),
        .tile_read_done (tile_read_done),
        .bank_wr_en     (bank_wr_en),
        .rd_bank        (rd_bank),
        .in_ready       (in_ready),
        .tile_ready     (tile_ready),
        .overflow       (overflow)
    );

    // Both banks see the same address, only the enable differs.
    tile_bank u_bank0 (
        .clk      (clk),
        .wr_en    (bank_wr_en[0]),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_pixel (in_pixel),
        .rd_row   (rd_row),
        .bank_row (bank_row0)
    );

    tile_bank u_bank1 (
        .clk      (clk),
        .wr_en    (bank_wr_en[1]),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_pixel (in_pixel),
        .rd_row   (rd_row),
        .bank_row (bank_row1)
    );

    row_reader u_reader (
        .clk            (clk),
        .reset          (reset),
        .out_row_req    (out_row_req),
        .tile_ready     (tile_ready),
        .rd_bank        (rd_bank),
        .bank_row0      (bank_row0),
        .bank_row1      (bank_row1),
        .rd_row         (rd_row),
        .tile_read_done (tile_read_done),
        .out_row_valid  (out_row_valid),
        .out_row        (out_row)
    );

endmodule

// File: hw/row_reader.sv
`include "tile_buffer_macros.svh"

module row_reader
    import tile_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      out_row_req,
    input  logic      tile_ready,
    input  logic      rd_bank,
    input  tile_row_t bank_row0,
    input  tile_row_t bank_row1,
    output tile_idx_t rd_row,
    output logic      tile_read_done,
    output logic      out_row_valid,
    output tile_row_t out_row
);

    localparam tile_idx_t last_idx = tile_idx_t'(`TILE_DIM - 1);

    logic req_ok;
    logic sel_q; // Bank that supplied the row in flight.

    assign req_ok         = out_row_req && tile_ready;
    assign tile_read_done = req_ok && (rd_row == last_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_row <= '0;
        end else if (req_ok) begin
            if (rd_row == last_idx) begin
                rd_row <= '0;
            end else begin
                rd_row <= rd_row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_row_valid <= 1'b0;
        end else begin
            out_row_valid <= req_ok;
        end
    end

    always_ff @(posedge clk) begin
        sel_q <= rd_bank;
    end

    // Lines up with the registered bank output.
    assign out_row = sel_q ? bank_row1 : bank_row0;

endmodule

// File: hw/pingpong_ctrl.sv
`include "tile_buffer_macros.svh"

module pingpong_ctrl
    import tile_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_pixel_valid,
    input  logic       tile_written,
    input  logic       tile_read_done,
    output logic [1:0] bank_wr_en,
    output logic       rd_bank,
    output logic       in_ready,
    output logic       tile_ready,
    output logic       overflow
);

    logic       wr_bank;  // Bank currently being filled.
    logic [1:0] full;     // Bank holds a complete tile.
    logic [1:0] full_nxt;
    logic       wr_ok;

    assign rd_bank    = ~wr_bank;
    assign in_ready   = ~full[wr_bank];
    assign tile_ready = full[rd_bank];

    assign wr_ok      = in_pixel_valid && in_ready;
    assign bank_wr_en = wr_ok ? (wr_bank ? 2'b10 : 2'b01) : 2'b00;

    // Full flags after this cycle's events.
    always_comb begin
        full_nxt = full;
        if (tile_written) begin
            full_nxt[wr_bank] = 1'b1;
        end
        if (tile_read_done) begin
            full_nxt[rd_bank] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_bank  <= 1'b0;
            full     <= '0;
            overflow <= 1'b0;
        end else begin
            full <= full_nxt;
            // Swap once the filled tile has somewhere to go.
            if (full_nxt[wr_bank] && !full_nxt[rd_bank]) begin
                wr_bank <= rd_bank;
            end
            if (in_pixel_valid && !in_ready) begin
                overflow <= 1'b1; // Sticky until reset.
            end
        end
    end

    a_wr_en_onehot : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bank_wr_en)
    ) else $error("both banks enabled for write");

    a_no_write_full : assert property (
        @(posedge clk) disable iff (reset)
        (bank_wr_en & full) == 2'b00
    ) else $error("write steered into a full bank");

    // Filling the last free bank while the other is still unread blocks input.
    a_backpressure : assert property (
        @(posedge clk) disable iff (reset)
        (tile_written && tile_ready && !tile_read_done) |=> !in_ready
    ) else $error("input not held off with both banks full");

endmodule

// File: hw/tile_bank.sv
`include "tile_buffer_macros.svh"

module tile_bank
    import tile_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  tile_idx_t wr_row,
    input  tile_idx_t wr_col,
    input  pixel_t    wr_pixel,
    input  tile_idx_t rd_row,
    output tile_row_t bank_row
);

    // One packed row per entry.
    tile_row_t rows [`TILE_DIM];

    // Single pixel lands in its column slot.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            rows[wr_row][wr_col] <= wr_pixel;
        end
    end

    // Row read is registered every cycle.
    always_ff @(posedge clk) begin
        bank_row <= rows[rd_row];
    end

endmodule

// File: hw/pixel_write_addr.sv
`include "tile_buffer_macros.svh"

module pixel_write_addr
    import tile_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_frame_start,
    input  logic      wr_any,
    output tile_idx_t wr_row,
    output tile_idx_t wr_col,
    output logic      tile_written
);

    localparam tile_idx_t last_idx = tile_idx_t'(`TILE_DIM - 1);

    logic last_col;
    logic last_pixel;

    assign last_col   = (wr_col == last_idx);
    assign last_pixel = last_col && (wr_row == last_idx);

    // Frame start wins over a write in the same cycle.
    assign tile_written = wr_any && last_pixel && !in_frame_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_row <= '0;
            wr_col <= '0;
        end else if (in_frame_start) begin
            wr_row <= '0; // Partial tile is dropped.
            wr_col <= '0;
        end else if (wr_any) begin
            if (last_col) begin
                wr_col <= '0;
                if (last_pixel) begin
                    wr_row <= '0;
                end else begin
                    wr_row <= wr_row + 1'b1;
                end
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    a_pos_in_tile : assert property (
        @(posedge clk) disable iff (reset)
        (wr_col < `TILE_DIM) && (wr_row < `TILE_DIM)
    ) else $error("write position outside tile: row %0d col %0d", wr_row, wr_col);

endmodule

// File: hw/tile_buffer_pkg.sv
`include "tile_buffer_macros.svh"

package tile_buffer_pkg;

    // One pixel sample.
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Ascending packed range, so column 0 lands in the top byte.
    typedef pixel_t [0:`TILE_DIM-1] tile_row_t;

    // Row or column position inside a tile.
    typedef logic [`TILE_IDX_W-1:0] tile_idx_t;

endpackage

// File: hw/tile_buffer_macros.svh
`ifndef TILE_BUFFER_MACROS_SVH
`define TILE_BUFFER_MACROS_SVH

// Tile is square.
`define TILE_DIM   34

// Bits per pixel.
`define PIXEL_W    8

// Wide enough for 0..TILE_DIM-1.
`define TILE_IDX_W 6

`endif
